// ==== src/lc_pkg.sv ====
// Shared life cycle encodings, payload structs and sizes, referenced by scoped name from all RTL
package lc_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Multibit enable width
  localparam int TxWidth    = 4;
  // Buffered copies of each synchronized enable
  localparam int NumCopies  = 2;
  // State encoding width
  localparam int StateWidth = 5;
  // Escalation cause code width
  localparam int CauseWidth = 4;
  // Wishbone data and word address widths
  localparam int DataWidth  = 32;
  localparam int AddrWidth  = 1;

  // Register word addresses
  localparam logic [AddrWidth-1:0] AddrStatus     = 1'b0;
  localparam logic [AddrWidth-1:0] AddrTransition = 1'b1;

  ////////////////////
  // Types
  ////////////////////

  // Multibit enable, any value besides On and Off is a transient or a fault
  typedef enum logic [TxWidth-1:0] {
    On  = 4'b0101,
    Off = 4'b1010
  } lc_tx_t;

  // Life cycle states, pairwise at least two bits apart
  typedef enum logic [StateWidth-1:0] {
    StRaw   = 5'b00000,
    StTest  = 5'b00111,
    StDev   = 5'b11001,
    StProd  = 5'b11110,
    StScrap = 5'b01010
  } lc_state_e;

  // Decoded function enables
  typedef struct packed {
    lc_tx_t dbg_en;
    lc_tx_t nvm_en;
  } lc_en_t;

  // Transition request from the register port
  typedef struct packed {
    logic      valid;
    lc_state_e target;
  } lc_req_t;

  // Escalation payload
  typedef struct packed {
    lc_tx_t                scrap;
    logic [CauseWidth-1:0] cause;
  } esc_t;

  // Status word, zero-extended on a register read
  typedef struct packed {
    lc_state_e             state;
    logic                  trans_err;
    logic                  escalated;
    logic [CauseWidth-1:0] cause;
  } lc_status_t;

  // Safe idle values
  localparam esc_t   EscIdle = '{scrap: Off, cause: '0};
  localparam lc_en_t LcEnOff = '{dbg_en: Off, nvm_en: Off};

endpackage

// ==== src/lc_double_sync.sv ====
// Two-flop synchronizer for any packed payload, loading a safe value on reset
module lc_double_sync #(
  // Payload type carried through both stages
  parameter type      payload_t  = logic,
  // Value both stages take on reset
  parameter payload_t ResetValue = payload_t'('0)
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // First stage may go metastable
  payload_t meta_q;
  // Second stage feeds the consumers
  payload_t sync_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      meta_q <= ResetValue;
      sync_q <= ResetValue;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule

// ==== src/lc_sync.sv ====
// Synchronizes one multibit life cycle enable and fans it out into separate copies
module lc_sync #(
  // Number of separately generated output copies
  parameter int NumCopies = lc_pkg::NumCopies
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  lc_pkg::lc_tx_t                  lc_en_i,
  output lc_pkg::lc_tx_t [NumCopies-1:0]  lc_en_o
);

  // Synchronized enable, Off out of reset
  lc_pkg::lc_tx_t lc_en;

  lc_double_sync #(
    .payload_t (lc_pkg::lc_tx_t),
    .ResetValue(lc_pkg::Off)
  ) u_double_sync (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (lc_en_i),
    .q_o  (lc_en)
  );

  // One copy per consumer, each bit driven on its own
  for (genvar j = 0; j < NumCopies; j++) begin : gen_copies
    logic [lc_pkg::TxWidth-1:0] en_copy;
    for (genvar k = 0; k < lc_pkg::TxWidth; k++) begin : gen_bits
      assign en_copy[k] = lc_en[k];
    end
    assign lc_en_o[j] = lc_pkg::lc_tx_t'(en_copy);
  end

  ////////////////////
  // Assertions
  ////////////////////

  initial assert (NumCopies > 0) else $error("NumCopies must be greater than zero");

  // Copies stay known once out of reset
  assert property (@(posedge clk_i) disable iff (rst_i) !$isunknown(lc_en_o));

  // A transient input settles after one cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
    !(lc_en_i inside {lc_pkg::On, lc_pkg::Off}) |=> (lc_en_i inside {lc_pkg::On, lc_pkg::Off}));

  // Leaving Off through a transient must land on On
  assert property (@(posedge clk_i) disable iff (rst_i)
    $past(lc_en_i == lc_pkg::Off) && !(lc_en_i inside {lc_pkg::On, lc_pkg::Off})
    |=> (lc_en_i == lc_pkg::On));

  // Leaving On through a transient must land on Off
  assert property (@(posedge clk_i) disable iff (rst_i)
    $past(lc_en_i == lc_pkg::On) && !(lc_en_i inside {lc_pkg::On, lc_pkg::Off})
    |=> (lc_en_i == lc_pkg::Off));

endmodule

// ==== src/lc_state_fsm.sv ====
// Life cycle state register with forward-only transitions, escalation to SCRAP and enable decode
module lc_state_fsm (
  input  logic               clk_i,
  input  logic               rst_i,
  input  lc_pkg::lc_req_t    req_i,
  input  lc_pkg::esc_t       esc_i,
  output lc_pkg::lc_status_t status_o,
  output lc_pkg::lc_en_t     lc_en_o
);

  // Position in the life cycle order, zero for an invalid code
  function automatic logic [2:0] state_rank(lc_pkg::lc_state_e st);
    logic [2:0] rank;
    case (st)
      lc_pkg::StRaw:   rank = 3'd1;
      lc_pkg::StTest:  rank = 3'd2;
      lc_pkg::StDev:   rank = 3'd3;
      lc_pkg::StProd:  rank = 3'd4;
      lc_pkg::StScrap: rank = 3'd5;
      default:         rank = 3'd0;
    endcase
    return rank;
  endfunction

  lc_pkg::lc_state_e             state_q;
  logic                          trans_err_q;
  logic                          escalated_q;
  logic [lc_pkg::CauseWidth-1:0] cause_q;
  lc_pkg::lc_en_t                en_q;

  logic esc_active;
  logic req_legal;

  // Only an exact On requests scrapping
  assign esc_active = (esc_i.scrap == lc_pkg::On);

  // SCRAP always allowed, otherwise the target must come later
  assign req_legal = (req_i.target == lc_pkg::StScrap) ||
                     (state_rank(req_i.target) > state_rank(state_q));

  ////////////////////
  // State and flags
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= lc_pkg::StRaw;
      trans_err_q <= 1'b0;
      escalated_q <= 1'b0;
      cause_q     <= '0;
    end else if (esc_active) begin
      // Escalation wins over any request in the same cycle
      state_q     <= lc_pkg::StScrap;
      escalated_q <= 1'b1;
      cause_q     <= esc_i.cause;
    end else if (req_i.valid) begin
      if (req_legal) begin
        state_q <= req_i.target;
      end else begin
        trans_err_q <= 1'b1;
      end
    end
  end

  ////////////////////
  // Enable decode
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q <= lc_pkg::LcEnOff;
    end else if (esc_active) begin
      // Drop enables alongside the state update, one cycle early
      en_q <= lc_pkg::LcEnOff;
    end else begin
      en_q.dbg_en <= (state_q inside {lc_pkg::StTest, lc_pkg::StDev}) ? lc_pkg::On : lc_pkg::Off;
      en_q.nvm_en <= (state_q inside {lc_pkg::StTest, lc_pkg::StDev, lc_pkg::StProd}) ?
                     lc_pkg::On : lc_pkg::Off;
    end
  end

  assign status_o = '{state: state_q, trans_err: trans_err_q,
                      escalated: escalated_q, cause: cause_q};
  assign lc_en_o  = en_q;

  // State register holds a defined encoding
  assert property (@(posedge clk_i) disable iff (rst_i)
    state_q inside {lc_pkg::StRaw, lc_pkg::StTest, lc_pkg::StDev, lc_pkg::StProd, lc_pkg::StScrap});

  // Decoded enables never carry transients
  assert property (@(posedge clk_i) disable iff (rst_i)
    (lc_en_o.dbg_en inside {lc_pkg::On, lc_pkg::Off}) &&
    (lc_en_o.nvm_en inside {lc_pkg::On, lc_pkg::Off}));

endmodule

// ==== src/lc_wb_regs.sv ====
// Wishbone classic register port for life cycle status and transition requests
module lc_wb_regs (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Wishbone slave
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [lc_pkg::AddrWidth-1:0] wb_adr_i,
  input  logic [lc_pkg::DataWidth-1:0] wb_dat_i,
  output logic [lc_pkg::DataWidth-1:0] wb_dat_o,
  output logic                         wb_ack_o,
  // Escalation, asynchronous in and synchronized out
  input  lc_pkg::esc_t                 esc_i,
  output lc_pkg::esc_t                 esc_o,
  // State machine side
  input  lc_pkg::lc_status_t           status_i,
  output lc_pkg::lc_req_t              req_o
);

  logic                         ack_q;
  logic                         req_valid_q;
  lc_pkg::lc_state_e            req_target_q;
  logic [lc_pkg::DataWidth-1:0] rdata_q;

  // New access, masked while acking so a held strobe is not acked twice
  logic access;
  logic wr_transition;
  logic rd_status;

  assign access        = wb_cyc_i && wb_stb_i && !ack_q;
  assign wr_transition = access && wb_we_i && (wb_adr_i == lc_pkg::AddrTransition);
  assign rd_status     = access && !wb_we_i && (wb_adr_i == lc_pkg::AddrStatus);

  ////////////////////
  // Handshake
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q       <= 1'b0;
      req_valid_q <= 1'b0;
    end else begin
      ack_q       <= access;
      // Request valid lines up with the ack cycle
      req_valid_q <= wr_transition;
    end
  end

  // Payload registers, loaded every cycle
  always_ff @(posedge clk_i) begin
    req_target_q <= lc_pkg::lc_state_e'(wb_dat_i[lc_pkg::StateWidth-1:0]);
    // Other addresses read back zero
    rdata_q      <= rd_status ? lc_pkg::DataWidth'(status_i) : '0;
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rdata_q;
  assign req_o    = '{valid: req_valid_q, target: req_target_q};

  // Escalation arrives two cycles late and idles on reset
  lc_double_sync #(
    .payload_t (lc_pkg::esc_t),
    .ResetValue(lc_pkg::EscIdle)
  ) u_esc_sync (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (esc_i),
    .q_o  (esc_o)
  );

  // Single-cycle ack, no back-to-back acks
  assert property (@(posedge clk_i) disable iff (rst_i) wb_ack_o |=> !wb_ack_o);

endmodule

// ==== src/lc_ctrl_top.sv ====
// Life cycle controller top, register port through state machine to synchronized enable copies
module lc_ctrl_top (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // Wishbone slave
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [lc_pkg::AddrWidth-1:0]           wb_adr_i,
  input  logic [lc_pkg::DataWidth-1:0]           wb_dat_i,
  output logic [lc_pkg::DataWidth-1:0]           wb_dat_o,
  output logic                                   wb_ack_o,
  // Asynchronous escalation
  input  lc_pkg::esc_t                           esc_i,
  // Buffered enable copies
  output lc_pkg::lc_tx_t [lc_pkg::NumCopies-1:0] dbg_en_o,
  output lc_pkg::lc_tx_t [lc_pkg::NumCopies-1:0] nvm_en_o
);

  lc_pkg::esc_t       esc_sync;
  lc_pkg::lc_status_t status;
  lc_pkg::lc_req_t    req;
  lc_pkg::lc_en_t     lc_en;

  lc_wb_regs u_wb_regs (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_we_i (wb_we_i),
    .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o),
    .esc_i   (esc_i),
    .esc_o   (esc_sync),
    .status_i(status),
    .req_o   (req)
  );

  lc_state_fsm u_state_fsm (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (req),
    .esc_i   (esc_sync),
    .status_o(status),
    .lc_en_o (lc_en)
  );

  // Debug enable
  lc_sync #(.NumCopies(lc_pkg::NumCopies)) u_sync_dbg (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .lc_en_i(lc_en.dbg_en),
    .lc_en_o(dbg_en_o)
  );

  // NVM enable
  lc_sync #(.NumCopies(lc_pkg::NumCopies)) u_sync_nvm (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .lc_en_i(lc_en.nvm_en),
    .lc_en_o(nvm_en_o)
  );

endmodule

// ==== sim/lc_ctrl_tb.sv ====
// Self-checking testbench for the life cycle controller that replays the vector file on the DUT
module lc_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                                   clk_i;
  logic                                   rst_i;
  logic                                   wb_cyc_i;
  logic                                   wb_stb_i;
  logic                                   wb_we_i;
  logic [lc_pkg::AddrWidth-1:0]           wb_adr_i;
  logic [lc_pkg::DataWidth-1:0]           wb_dat_i;
  logic [lc_pkg::DataWidth-1:0]           wb_dat_o;
  logic                                   wb_ack_o;
  lc_pkg::esc_t                           esc_i;
  lc_pkg::lc_tx_t [lc_pkg::NumCopies-1:0] dbg_en_o;
  lc_pkg::lc_tx_t [lc_pkg::NumCopies-1:0] nvm_en_o;

  // Five words per vector line and room for 64 lines
  logic [31:0] vec_mem [0:319];

  int cycle_cnt;
  int cycle_limit;
  int error_cnt;
  int tests_run;
  int tests_failed;
  // Enables before the current operation as {dbg_en, nvm_en}
  logic [7:0] prev_en;

  lc_ctrl_top uut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_we_i (wb_we_i),
    .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o),
    .esc_i   (esc_i),
    .dbg_en_o(dbg_en_o),
    .nvm_en_o(nvm_en_o)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Run limit from the number of vector lines
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run stopped after %0d cycles before the vectors were done", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      error_cnt++;
    end
  endtask

  function automatic logic is_tx_valid(input logic [3:0] v);
    return (v === lc_pkg::On) || (v === lc_pkg::Off);
  endfunction

  // Every copy must match and be exactly On or Off
  task automatic check_enables(input logic [7:0] exp);
    logic [3:0] dbg;
    logic [3:0] nvm;
    for (int j = 0; j < lc_pkg::NumCopies; j++) begin
      dbg = dbg_en_o[j];
      nvm = nvm_en_o[j];
      check_value($sformatf("dbg_en_o[%0d]", j), dbg, exp[7:4]);
      check_value($sformatf("nvm_en_o[%0d]", j), nvm, exp[3:0]);
      if (!is_tx_valid(dbg) || !is_tx_valid(nvm)) begin
        $display("Enable copy %0d holds a value that is neither On nor Off", j);
        error_cnt++;
      end
    end
  endtask

  ////////////////////
  // Bus access
  ////////////////////

  // Starts on a falling edge and returns on the falling edge after the ack cycle
  task automatic wb_access(input logic we, input logic [lc_pkg::AddrWidth-1:0] adr,
                           input logic [31:0] dat, output logic [31:0] rdata);
    int wait_cnt;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(negedge clk_i);
    wait_cnt = 1;
    while (wb_ack_o !== 1'b1 && wait_cnt < 8) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (wb_ack_o !== 1'b1) begin
      $display("No ack within %0d cycles of a Wishbone access", wait_cnt);
      error_cnt++;
    end else if (wait_cnt != 1) begin
      $display("Ack came %0d cycles after the strobe instead of one", wait_cnt);
      error_cnt++;
    end
    rdata    = wb_dat_o;
    // Strobe dropped in the ack cycle
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk_i);
    if (wb_ack_o !== 1'b0) begin
      $display("Ack stayed high for more than one cycle");
      error_cnt++;
    end
  endtask

  task automatic close_test(input int num, input int errs);
    tests_run++;
    if (errs == 0) begin
      $display("Test %0d passed", num);
    end else begin
      tests_failed++;
      $display("Test %0d failed with %0d errors", num, errs);
    end
  endtask

  ////////////////////
  // Vector replay
  ////////////////////

  initial begin
    int line_cnt;
    int cur_test;
    int test_err_start;
    int test_no;
    logic [31:0] op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] expv;
    logic [31:0] rdata;

    rst_i        = 1'b1;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    esc_i        = lc_pkg::EscIdle;
    cycle_cnt    = 0;
    error_cnt    = 0;
    tests_run    = 0;
    tests_failed = 0;
    // Both enables Off out of reset
    prev_en      = 8'hAA;
    void'($urandom(12868));

    $readmemh("sim/lc_ctrl_vectors.txt", vec_mem);
    // Count lines up to the end marker with op code zero
    line_cnt = 0;
    while (line_cnt < 64 && (vec_mem[5*line_cnt+1] inside {[1:4]})) begin
      line_cnt++;
    end
    cycle_limit = 40 * line_cnt + 8;
    if (line_cnt == 0) begin
      $display("No vector lines were read from the vector file");
      error_cnt++;
    end

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    cur_test       = -1;
    test_err_start = 0;
    for (int rec = 0; rec < line_cnt; rec++) begin
      test_no = vec_mem[5*rec];
      op      = vec_mem[5*rec+1];
      adr     = vec_mem[5*rec+2];
      dat     = vec_mem[5*rec+3];
      expv    = vec_mem[5*rec+4];
      if (test_no != cur_test) begin
        if (cur_test >= 0) close_test(cur_test, error_cnt - test_err_start);
        cur_test       = test_no;
        test_err_start = error_cnt;
      end
      case (op)
        1: begin
          // Enables move on the fourth edge after the ack edge
          wb_access(1'b1, adr[lc_pkg::AddrWidth-1:0], dat, rdata);
          repeat (2) @(negedge clk_i);
          check_enables(prev_en);
          @(negedge clk_i);
          check_enables(expv[7:0]);
          prev_en = expv[7:0];
        end
        2: begin
          wb_access(1'b0, adr[lc_pkg::AddrWidth-1:0], dat, rdata);
          check_value("wb_dat_o", rdata, expv);
        end
        3: begin
          // Enables drop on the fifth edge after the change
          esc_i = lc_pkg::esc_t'(dat[7:0]);
          repeat (4) @(negedge clk_i);
          check_enables(prev_en);
          @(negedge clk_i);
          check_enables(expv[7:0]);
          prev_en = expv[7:0];
        end
        default: begin
          repeat (dat) @(negedge clk_i);
          check_enables(expv[7:0]);
        end
      endcase
      repeat ($urandom_range(3)) @(negedge clk_i);
    end
    if (cur_test >= 0) close_test(cur_test, error_cnt - test_err_start);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, error_cnt);
    if (error_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/lc_ctrl_vectors.txt ====
// Columns in hex: test, op (1 write, 2 read, 3 escalate, 4 wait), address, data, expected
// Write, escalate and wait expect {dbg_en, nvm_en}, read expects wb_dat_o, wait idles data cycles
// Test 1 out of reset
1 4 0 00 AA
1 2 0 00 000
1 2 1 00 000
// Test 2 forward transitions RAW, TEST, DEV, PROD
2 1 1 07 55
2 2 0 00 1C0
2 1 1 19 55
2 2 0 00 640
2 1 1 1E A5
2 2 0 00 780
// Test 3 backward request and a write to the status word
3 1 1 19 A5
3 2 0 00 7A0
3 1 0 07 A5
3 2 0 00 7A0
// Test 4 escalation with cause C, release, then a rejected request
4 3 0 5C AA
4 2 0 00 2BC
4 3 0 A0 AA
4 1 1 19 AA
4 2 0 00 2BC
4 4 0 03 AA
// End marker
0 0 0 00 00

// ==== project.f ====
src/lc_pkg.sv
src/lc_double_sync.sv
src/lc_sync.sv
src/lc_state_fsm.sv
src/lc_wb_regs.sv
src/lc_ctrl_top.sv
sim/lc_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: lc_ctrl

dependencies: {}

sources:
  - src/lc_pkg.sv
  - src/lc_double_sync.sv
  - src/lc_sync.sv
  - src/lc_state_fsm.sv
  - src/lc_wb_regs.sv
  - src/lc_ctrl_top.sv
  - target: simulation
    files:
      - sim/lc_ctrl_tb.sv
